// ==== verilog/mmu_defines.svh ====
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

`define TLB_ENTRIES 32
`define TLB_IDXW    5
`define PALEN       32
`define VPPNW       19
`define PPNW        (`PALEN-12)      // 4 KB pages only
`define ASIDW       10

// management op codes
`define OP_SRCH     2'd1
`define OP_RD       2'd2
`define OP_WR       2'd3

`define OPT_FETCH   2'd0
`define OPT_LOAD    2'd1
`define OPT_STORE   2'd2

`define EXC_TLBR    6'h3f
`define EXC_PIL     6'h01
`define EXC_PIS     6'h02
`define EXC_PIF     6'h03
`define EXC_PME     6'h04
`define EXC_PPI     6'h07
`define EXC_ADE     6'h08

`define SUB_ADEF    9'h000
`define SUB_ADEM    9'h001

// valid, subcode, code
`define EXCW        16

`endif

// ==== verilog/mmuPkg.sv ====
`include "mmu_defines.svh"

package mmuPkg;

    typedef struct packed {
        logic [2:0]  seg;               // compared against DMW[31:29]
        logic [28:0] offset;
    } winViewT;

    typedef struct packed {
        logic [`VPPNW-1:0] vppn;
        logic              odd;         // selects odd page half
        logic [11:0]       offset;
    } pageViewT;

    typedef union packed {
        winViewT  win;
        pageViewT page;
    } vaddrT;

endpackage

// ==== verilog/tlbEntries.sv ====
`timescale 1ns/1ns
`include "mmu_defines.svh"

module tlbEntries
    import mmuPkg::*;
(
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           wrEn,
    input  logic [`TLB_IDXW-1:0]           wrIdx,
    input  vaddrT                          wrVaddr,
    input  logic [`ASIDW-1:0]              wrAsid,
    input  logic [31:0]                    wrElo0,
    input  logic [31:0]                    wrElo1,
    input  logic                           wrNe,
    input  logic [`TLB_IDXW-1:0]           rdIdx,
    input  logic [`TLB_IDXW-1:0]           lkIdx,
    input  logic                           lkOdd,
    output logic [`TLB_ENTRIES*`VPPNW-1:0] entVppn,
    output logic [`TLB_ENTRIES*`ASIDW-1:0] entAsid,
    output logic [`TLB_ENTRIES-1:0]        entG,
    output logic [`TLB_ENTRIES-1:0]        entE,
    output logic [`VPPNW-1:0]              rdVppn,
    output logic [`ASIDW-1:0]              rdAsid,
    output logic                           rdG,
    output logic                           rdE,
    output logic [`PPNW+5:0]               rdElo0,
    output logic [`PPNW+5:0]               rdElo1,
    output logic [`PPNW-1:0]               lkPpn,
    output logic [1:0]                     lkPlv,
    output logic [1:0]                     lkMat,
    output logic                           lkD,
    output logic                           lkV
);
    logic [`VPPNW-1:0] vppnMem [`TLB_ENTRIES];
    logic [`ASIDW-1:0] asidMem [`TLB_ENTRIES];
    logic [`PPNW+5:0]  elo0Mem [`TLB_ENTRIES];    // {ppn, mat, plv, d, v}
    logic [`PPNW+5:0]  elo1Mem [`TLB_ENTRIES];
    logic [`PPNW+5:0]  lkElo;

    always_ff @(posedge clk)
    begin
        if (wrEn)
        begin
            vppnMem[wrIdx] <= wrVaddr.page.vppn;
            asidMem[wrIdx] <= wrAsid;
            elo0Mem[wrIdx] <= {wrElo0[`PPNW+7:8], wrElo0[5:0]};
            elo1Mem[wrIdx] <= {wrElo1[`PPNW+7:8], wrElo1[5:0]};
            entG[wrIdx]    <= wrElo0[6] & wrElo1[6];    // global only if both halves say so
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            entE <= '0;
        else if (wrEn)
            entE[wrIdx] <= !wrNe;
    end

    for (genvar i = 0; i < `TLB_ENTRIES; i++)
    begin : genFlat
        assign entVppn[i*`VPPNW +: `VPPNW] = vppnMem[i];
        assign entAsid[i*`ASIDW +: `ASIDW] = asidMem[i];
    end

    assign rdVppn = vppnMem[rdIdx];
    assign rdAsid = asidMem[rdIdx];
    assign rdG    = entG[rdIdx];
    assign rdE    = entE[rdIdx];
    assign rdElo0 = elo0Mem[rdIdx];
    assign rdElo1 = elo1Mem[rdIdx];

    assign lkElo = lkOdd ? elo1Mem[lkIdx] : elo0Mem[lkIdx];
    assign lkPpn = lkElo[`PPNW+5:6];
    assign {lkMat, lkPlv, lkD, lkV} = lkElo[5:0];

    // index and enable of a write must be known
    wrIdxKnown: assert property (@(posedge clk) disable iff (!rstN)
        wrEn |-> !$isunknown({wrIdx, wrNe}))
        else $error("tlbEntries: write with unknown index %0d", wrIdx);

endmodule

// ==== verilog/tlbMatch.sv ====
`timescale 1ns/1ns
`include "mmu_defines.svh"

module tlbMatch
(
    input  logic [`TLB_ENTRIES*`VPPNW-1:0] entVppn,
    input  logic [`TLB_ENTRIES*`ASIDW-1:0] entAsid,
    input  logic [`TLB_ENTRIES-1:0]        entG,
    input  logic [`TLB_ENTRIES-1:0]        entE,
    input  logic [`VPPNW-1:0]              vppn,
    input  logic [`ASIDW-1:0]              asid,
    output logic                           hit,
    output logic [`TLB_IDXW-1:0]           hitIdx
);
    logic [`TLB_ENTRIES-1:0] matchVec;

    always_comb
    begin
        for (int i = 0; i < `TLB_ENTRIES; i++)
        begin
            matchVec[i] = entE[i]
                && (entVppn[i*`VPPNW +: `VPPNW] == vppn)
                && (entG[i] || entAsid[i*`ASIDW +: `ASIDW] == asid);
        end
    end

    // highest set index wins
    always_comb
    begin
        hitIdx = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++)
        begin
            if (matchVec[i])
                hitIdx = `TLB_IDXW'(i);
        end
    end

    assign hit = |matchVec;

    // entries written by software must never overlap
    always_comb
    begin
        multiHit: assert ($onehot0(matchVec))
            else $error("tlbMatch: several entries hit vppn %h asid %h", vppn, asid);
    end

endmodule

// ==== verilog/tlbControl.sv ====
`timescale 1ns/1ns
`include "mmu_defines.svh"

module tlbControl
    import mmuPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 opValid,
    input  logic [1:0]           opCode,
    input  logic                 stallW,
    input  logic [31:0]          tlbIdxIn,
    input  vaddrT                tlbEhiIn,
    input  logic [31:0]          tlbElo0In,
    input  logic [31:0]          tlbElo1In,
    input  logic [`ASIDW-1:0]    asid,
    input  logic                 srchHit,
    input  logic [`TLB_IDXW-1:0] srchIdx,
    input  logic [`VPPNW-1:0]    rdVppn,
    input  logic [`ASIDW-1:0]    rdAsid,
    input  logic                 rdG,
    input  logic                 rdE,
    input  logic [`PPNW+5:0]     rdElo0,
    input  logic [`PPNW+5:0]     rdElo1,
    output logic                 wrEn,
    output logic [31:0]          tlbIdxOut,
    output logic [31:0]          tlbEhiOut,
    output logic [31:0]          tlbElo0Out,
    output logic [31:0]          tlbElo1Out,
    output logic [`ASIDW-1:0]    asidOut
);
    logic [31:0]       idxNext;
    logic [31:0]       ehiNext;
    logic [31:0]       elo0Next;
    logic [31:0]       elo1Next;
    logic [`ASIDW-1:0] asidNext;

    assign wrEn = opValid && !stallW && (opCode == `OP_WR);

    always_comb
    begin
        idxNext  = tlbIdxIn;
        ehiNext  = tlbEhiIn;
        elo0Next = tlbElo0In;
        elo1Next = tlbElo1In;
        asidNext = asid;
        if (opValid && opCode == `OP_SRCH)
        begin
            idxNext[31] = !srchHit;    // NE
            if (srchHit)
                idxNext[`TLB_IDXW-1:0] = srchIdx;
        end
        else if (opValid && opCode == `OP_RD)
        begin
            if (rdE)
            begin
                idxNext[31] = 1'b0;
                ehiNext  = {rdVppn, tlbEhiIn.page.odd, tlbEhiIn.page.offset};
                elo0Next = {tlbElo0In[31:28], rdElo0[`PPNW+5:6], tlbElo0In[7], rdG, rdElo0[5:0]};
                elo1Next = {tlbElo1In[31:28], rdElo1[`PPNW+5:6], tlbElo1In[7], rdG, rdElo1[5:0]};
                asidNext = rdAsid;
            end
            else
            begin
                idxNext  = {1'b1, 31'b0};
                ehiNext  = '0;
                elo0Next = '0;
                elo1Next = '0;
                asidNext = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            tlbIdxOut  <= '0;
            tlbEhiOut  <= '0;
            tlbElo0Out <= '0;
            tlbElo1Out <= '0;
            asidOut    <= '0;
        end
        else if (!stallW)
        begin
            tlbIdxOut  <= idxNext;
            tlbEhiOut  <= ehiNext;
            tlbElo0Out <= elo0Next;
            tlbElo1Out <= elo1Next;
            asidOut    <= asidNext;
        end
    end

    opLegal: assert property (@(posedge clk) disable iff (!rstN)
        opValid |-> opCode != 2'd0)
        else $error("tlbControl: valid op with code 0");

endmodule

// ==== verilog/addrTranslate.sv ====
`timescale 1ns/1ns
`include "mmu_defines.svh"

module addrTranslate
    import mmuPkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    input  vaddrT             vaddr,
    input  logic              vaddrValid,
    input  logic [1:0]        opType,
    input  logic              stall0,
    input  logic [8:0]        crmd,
    input  logic [31:0]       dmw0,
    input  logic [31:0]       dmw1,
    input  logic              lkHit,
    input  logic [`PPNW-1:0]  lkPpn,
    input  logic [1:0]        lkPlv,
    input  logic [1:0]        lkMat,
    input  logic              lkD,
    input  logic              lkV,
    output logic              paddrValid,
    output logic [31:0]       paddr,
    output logic [`EXCW-1:0]  excpArg,
    output logic [1:0]        memType
);
    logic [1:0]       plv;
    logic             daMode;
    logic             dmw0Hit;
    logic             dmw1Hit;
    logic [31:0]      paddrNext;
    logic [1:0]       memTypeNext;
    logic [`EXCW-1:0] excpNext;

    function automatic logic windowHit(input logic [31:0] dmw, input logic [1:0] curPlv,
                                       input logic [2:0] seg);
        logic plvOk;
        plvOk = (dmw[0] && curPlv == 2'd0) || (dmw[3] && curPlv == 2'd3);
        return plvOk && (dmw[31:29] == seg);
    endfunction

    assign plv     = crmd[1:0];
    assign daMode  = crmd[4:3] == 2'b01;    // DA=1, PG=0
    assign dmw0Hit = windowHit(dmw0, plv, vaddr.win.seg);
    assign dmw1Hit = windowHit(dmw1, plv, vaddr.win.seg);

    always_comb
    begin
        // faults override only the exception word
        paddrNext   = {lkPpn, vaddr.page.offset};
        memTypeNext = lkMat;
        excpNext    = '0;
        if (daMode)
        begin
            paddrNext   = vaddr;
            memTypeNext = (opType == `OPT_FETCH) ? crmd[6:5] : crmd[8:7];
        end
        else if (dmw0Hit)
        begin
            paddrNext   = {dmw0[27:25], vaddr.win.offset};
            memTypeNext = dmw0[5:4];
        end
        else if (dmw1Hit)
        begin
            paddrNext   = {dmw1[27:25], vaddr.win.offset};
            memTypeNext = dmw1[5:4];
        end
        else if (plv != 2'd0 && vaddr.win.seg[2])
            excpNext = {vaddrValid, (opType == `OPT_FETCH) ? `SUB_ADEF : `SUB_ADEM, `EXC_ADE};
        else if (!lkHit)
            excpNext = {vaddrValid, 9'h0, `EXC_TLBR};
        else if (!lkV)
        begin
            case (opType)
                `OPT_FETCH: excpNext = {vaddrValid, 9'h0, `EXC_PIF};
                `OPT_LOAD:  excpNext = {vaddrValid, 9'h0, `EXC_PIL};
                default:    excpNext = {vaddrValid, 9'h0, `EXC_PIS};
            endcase
        end
        else if (plv > lkPlv)
            excpNext = {vaddrValid, 9'h0, `EXC_PPI};
        else if (opType == `OPT_STORE && !lkD)
            excpNext = {vaddrValid, 9'h0, `EXC_PME};    // clean page store
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            paddrValid <= 1'b0;
            paddr      <= '0;
            excpArg    <= '0;
            memType    <= '0;
        end
        else if (!stall0)
        begin
            paddrValid <= vaddrValid;
            paddr      <= paddrNext;
            excpArg    <= excpNext;
            memType    <= memTypeNext;
        end
    end

    opTypeLegal: assert property (@(posedge clk) disable iff (!rstN)
        vaddrValid |-> opType != 2'd3)
        else $error("addrTranslate: illegal opType with valid address");

endmodule

// ==== verilog/memMapUnit.sv ====
`timescale 1ns/1ns
`include "mmu_defines.svh"

module memMapUnit
    import mmuPkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    input  logic              opValid,
    input  logic [1:0]        opCode,
    input  logic [31:0]       tlbIdxIn,
    input  vaddrT             tlbEhiIn,
    input  logic [31:0]       tlbElo0In,
    input  logic [31:0]       tlbElo1In,
    input  logic [`ASIDW-1:0] asid,
    input  logic              stallW,
    output logic [31:0]       tlbIdxOut,
    output logic [31:0]       tlbEhiOut,
    output logic [31:0]       tlbElo0Out,
    output logic [31:0]       tlbElo1Out,
    output logic [`ASIDW-1:0] asidOut,
    input  vaddrT             vaddr,
    input  logic              vaddrValid,
    input  logic [1:0]        opType,
    input  logic              stall0,
    input  logic [8:0]        crmd,
    input  logic [31:0]       dmw0,
    input  logic [31:0]       dmw1,
    output logic              paddrValid,
    output logic [31:0]       paddr,
    output logic [`EXCW-1:0]  excpArg,
    output logic [1:0]        memType
);
    logic                           wrEn;
    logic [`TLB_ENTRIES*`VPPNW-1:0] entVppn;
    logic [`TLB_ENTRIES*`ASIDW-1:0] entAsid;
    logic [`TLB_ENTRIES-1:0]        entG;
    logic [`TLB_ENTRIES-1:0]        entE;
    logic                           srchHit;
    logic [`TLB_IDXW-1:0]           srchIdx;
    logic                           lkHit;
    logic [`TLB_IDXW-1:0]           lkIdx;
    logic [`VPPNW-1:0]              rdVppn;
    logic [`ASIDW-1:0]              rdAsid;
    logic                           rdG;
    logic                           rdE;
    logic [`PPNW+5:0]               rdElo0;
    logic [`PPNW+5:0]               rdElo1;
    logic [`PPNW-1:0]               lkPpn;
    logic [1:0]                     lkPlv;
    logic [1:0]                     lkMat;
    logic                           lkD;
    logic                           lkV;

    tlbEntries entries0 (
        .clk, .rstN, .wrEn,
        .wrIdx(tlbIdxIn[`TLB_IDXW-1:0]), .wrVaddr(tlbEhiIn), .wrAsid(asid),
        .wrElo0(tlbElo0In), .wrElo1(tlbElo1In), .wrNe(tlbIdxIn[31]),
        .rdIdx(tlbIdxIn[`TLB_IDXW-1:0]), .lkIdx, .lkOdd(vaddr.page.odd),
        .entVppn, .entAsid, .entG, .entE,
        .rdVppn, .rdAsid, .rdG, .rdE, .rdElo0, .rdElo1,
        .lkPpn, .lkPlv, .lkMat, .lkD, .lkV
    );

    tlbMatch srchMatch (
        .entVppn, .entAsid, .entG, .entE,
        .vppn(tlbEhiIn.page.vppn), .asid, .hit(srchHit), .hitIdx(srchIdx)
    );

    tlbMatch lookMatch (
        .entVppn, .entAsid, .entG, .entE,
        .vppn(vaddr.page.vppn), .asid, .hit(lkHit), .hitIdx(lkIdx)
    );

    tlbControl control0 (
        .clk, .rstN, .opValid, .opCode, .stallW,
        .tlbIdxIn, .tlbEhiIn, .tlbElo0In, .tlbElo1In, .asid,
        .srchHit, .srchIdx, .rdVppn, .rdAsid, .rdG, .rdE, .rdElo0, .rdElo1,
        .wrEn, .tlbIdxOut, .tlbEhiOut, .tlbElo0Out, .tlbElo1Out, .asidOut
    );

    addrTranslate translate0 (
        .clk, .rstN, .vaddr, .vaddrValid, .opType, .stall0, .crmd, .dmw0, .dmw1,
        .lkHit, .lkPpn, .lkPlv, .lkMat, .lkD, .lkV,
        .paddrValid, .paddr, .excpArg, .memType
    );

endmodule

// ==== bench/mmuClock.sv ====
`timescale 1ns/1ns

module mmuClock
(
    output logic clk,
    output logic rstN
);
    initial
    begin
        clk  = 1'b0;
        rstN = 1'b0;
        repeat (10) @(posedge clk);
        #1 rstN = 1'b1;    // release clear of the edge
    end

    always #2 clk = ~clk;    // 4 ns period

endmodule

// ==== bench/mmuBench.sv ====
`timescale 1ns/1ns
`include "mmu_defines.svh"

module mmuBench
    import mmuPkg::*;
();
    localparam int numWrites   = 40;
    localparam int numReads    = 64;
    localparam int numSearches = 64;
    localparam int numXlates   = 400;
    // each op may stall a few cycles
    localparam int cycleLimit  = 5 * (numWrites + numReads + numSearches + numXlates) + 160;

    logic clk, rstN, opValid, stallW, vaddrValid, stall0, paddrValid;
    logic [1:0] opCode, opType, memType;
    logic [31:0] tlbIdxIn, tlbElo0In, tlbElo1In, dmw0, dmw1, paddr;
    logic [31:0] tlbIdxOut, tlbEhiOut, tlbElo0Out, tlbElo1Out;
    logic [`ASIDW-1:0] asid, asidOut;
    logic [8:0] crmd;
    logic [`EXCW-1:0] excpArg;
    vaddrT tlbEhiIn, vaddr;

    // reference copy of the TLB
    logic [`VPPNW-1:0] mVppn [`TLB_ENTRIES];
    logic [`ASIDW-1:0] mAsid [`TLB_ENTRIES];
    logic [`PPNW+5:0]  mElo0 [`TLB_ENTRIES];    // {ppn, mat, plv, d, v}
    logic [`PPNW+5:0]  mElo1 [`TLB_ENTRIES];
    logic              mG    [`TLB_ENTRIES];
    logic              mE    [`TLB_ENTRIES];

    logic [31:0] hIdx, hEhi, hElo0, hElo1, hPaddr;    // last taken results
    logic [`ASIDW-1:0] hAsid;
    logic hValid;
    logic [`EXCW-1:0] hExcp;
    logic [1:0] hMem;
    logic [31:0] rngState = 32'hb472_a6f2;
    int mismatchCount = 0;
    int failCount = 0;
    int searchHits = 0;
    int cycleCount;

    mmuClock clock0 (.clk, .rstN);
    memMapUnit dut0 (.*);

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // {hit, index} of the highest matching entry
    function automatic logic [`TLB_IDXW:0] modelLookup(input logic [`VPPNW-1:0] v,
                                                      input logic [`ASIDW-1:0] a);
        logic [`TLB_IDXW:0] res;
        res = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++)
            if (mE[i] && mVppn[i] == v && (mG[i] || mAsid[i] == a))
                res = {1'b1, `TLB_IDXW'(i)};
        return res;
    endfunction

    function automatic logic winMatch(input logic [31:0] dmw, input logic [1:0] plv,
                                      input logic [2:0] seg);
        return ((dmw[0] && plv == 2'd0) || (dmw[3] && plv == 2'd3)) && dmw[31:29] == seg;
    endfunction

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            mismatchCount++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkExcp(input string name, input logic [`EXCW-1:0] got,
                             input logic [`EXCW-1:0] exp);
        if (got !== exp)
        begin
            mismatchCount++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkMemType(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
        begin
            mismatchCount++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            mismatchCount++;
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;    // drive and sample away from the edge
    endtask

    task automatic checkMgmtOutputs();
        checkWord("tlbIdxOut", tlbIdxOut, hIdx);
        checkWord("tlbEhiOut", tlbEhiOut, hEhi);
        checkWord("tlbElo0Out", tlbElo0Out, hElo0);
        checkWord("tlbElo1Out", tlbElo1Out, hElo1);
        checkWord("asidOut", 32'(asidOut), 32'(hAsid));
    endtask

    task automatic checkXlateOutputs();
        checkBit("paddrValid", paddrValid, hValid);
        checkWord("paddr", paddr, hPaddr);
        checkExcp("excpArg", excpArg, hExcp);
        checkMemType("memType", memType, hMem);
    endtask

    task automatic mgmtOp(input logic [1:0] op, input logic [31:0] idx, input logic [31:0] ehi,
                          input logic [31:0] elo0, input logic [31:0] elo1,
                          input logic [`ASIDW-1:0] a);
        logic [31:0] eIdx, eEhi, eElo0, eElo1;
        logic [`ASIDW-1:0] eAsid;
        logic [`TLB_IDXW:0] look;
        logic [`TLB_IDXW-1:0] i;
        logic stalled;
        eIdx  = idx;
        eEhi  = ehi;
        eElo0 = elo0;
        eElo1 = elo1;
        eAsid = a;
        i     = idx[`TLB_IDXW-1:0];
        look  = modelLookup(ehi[31:13], a);
        if (op == `OP_SRCH)
        begin
            eIdx[31] = !look[`TLB_IDXW];    // NE on miss
            if (look[`TLB_IDXW])
                eIdx[`TLB_IDXW-1:0] = look[`TLB_IDXW-1:0];
        end
        else if (op == `OP_RD && mE[i])
        begin
            eIdx[31] = 1'b0;
            eEhi  = {mVppn[i], ehi[12:0]};
            eElo0 = {elo0[31:28], mElo0[i][`PPNW+5:6], elo0[7], mG[i], mElo0[i][5:0]};
            eElo1 = {elo1[31:28], mElo1[i][`PPNW+5:6], elo1[7], mG[i], mElo1[i][5:0]};
            eAsid = mAsid[i];
        end
        else if (op == `OP_RD)
        begin
            eIdx  = 32'h8000_0000;
            eEhi  = '0;
            eElo0 = '0;
            eElo1 = '0;
            eAsid = '0;
        end
        opValid   = 1'b1;
        opCode    = op;
        tlbIdxIn  = idx;
        tlbEhiIn  = ehi;
        tlbElo0In = elo0;
        tlbElo1In = elo1;
        asid      = a;
        do
        begin
            stalled = (nextRand() & 32'h3) == 32'h0;
            stallW  = stalled;
            nextCycle();
            if (!stalled)
            begin
                hIdx  = eIdx;
                hEhi  = eEhi;
                hElo0 = eElo0;
                hElo1 = eElo1;
                hAsid = eAsid;
            end
            checkMgmtOutputs();
        end
        while (stalled);
        if (op == `OP_WR)
        begin
            mVppn[i] = ehi[31:13];
            mAsid[i] = a;
            mElo0[i] = {elo0[`PPNW+7:8], elo0[5:0]};
            mElo1[i] = {elo1[`PPNW+7:8], elo1[5:0]};
            mG[i]    = elo0[6] & elo1[6];
            mE[i]    = !idx[31];
        end
        opValid = 1'b0;
        stallW  = 1'b1;
    endtask

    task automatic writeEntry(input logic [`TLB_IDXW-1:0] i);
        logic [31:0] r, idxWord, ehiWord, elo0, elo1;
        logic glob;
        r       = nextRand();
        glob    = r[3:0] < 4'd4;
        idxWord = nextRand();
        ehiWord = nextRand();
        elo0    = nextRand();
        elo1    = nextRand();
        idxWord[`TLB_IDXW-1:0] = i;
        idxWord[31]  = r[7:6] == 2'b00;    // some entries left disabled
        ehiWord[17:13] = i;                 // low vppn bits keep entries apart
        elo0[6] = glob;
        elo1[6] = glob | r[4];
        mgmtOp(`OP_WR, idxWord, ehiWord, elo0, elo1, r[31:22]);
    endtask

    task automatic readEntry(input logic [`TLB_IDXW-1:0] i);
        logic [31:0] idxWord, r;
        idxWord = nextRand();
        r = nextRand();
        idxWord[`TLB_IDXW-1:0] = i;
        mgmtOp(`OP_RD, idxWord, nextRand(), nextRand(), nextRand(), r[9:0]);
    endtask

    task automatic searchEntry();
        logic [31:0] r, ehiWord;
        logic [`TLB_IDXW-1:0] k;
        logic [`ASIDW-1:0] a;
        logic [`TLB_IDXW:0] look;
        r = nextRand();
        ehiWord = nextRand();
        k = r[4:0];
        a = r[14:5];
        if (r[15])
            ehiWord[31:13] = mVppn[k];
        if (r[16])
            a = mAsid[k];
        look = modelLookup(ehiWord[31:13], a);
        if (look[`TLB_IDXW])
            searchHits++;
        mgmtOp(`OP_SRCH, nextRand(), ehiWord, nextRand(), nextRand(), a);
    endtask

    task automatic xlateOp(input logic [31:0] va, input logic [1:0] opt, input logic [8:0] cr,
                           input logic [31:0] d0, input logic [31:0] d1,
                           input logic [`ASIDW-1:0] a);
        logic [`TLB_IDXW:0] look;
        logic [`PPNW+5:0] half;
        logic [1:0] plv;
        logic valid, stalled;
        logic [31:0] ePaddr;
        logic [`EXCW-1:0] eExcp;
        logic [1:0] eMem;
        look   = modelLookup(va[31:13], a);
        half   = va[12] ? mElo1[look[`TLB_IDXW-1:0]] : mElo0[look[`TLB_IDXW-1:0]];
        plv    = cr[1:0];
        valid  = (nextRand() & 32'h7) != 32'h0;
        ePaddr = {half[`PPNW+5:6], va[11:0]};    // lookup result stays on a fault
        eMem   = half[5:4];
        eExcp  = '0;
        if (cr[4:3] == 2'b01)
        begin
            ePaddr = va;
            eMem   = (opt == `OPT_FETCH) ? cr[6:5] : cr[8:7];
        end
        else if (winMatch(d0, plv, va[31:29]))
        begin
            ePaddr = {d0[27:25], va[28:0]};
            eMem   = d0[5:4];
        end
        else if (winMatch(d1, plv, va[31:29]))
        begin
            ePaddr = {d1[27:25], va[28:0]};
            eMem   = d1[5:4];
        end
        else if (plv != 2'd0 && va[31])
            eExcp = {valid, (opt == `OPT_FETCH) ? `SUB_ADEF : `SUB_ADEM, `EXC_ADE};
        else if (!look[`TLB_IDXW])
            eExcp = {valid, 9'h0, `EXC_TLBR};
        else if (!half[0])
            eExcp = {valid, 9'h0, (opt == `OPT_FETCH) ? `EXC_PIF :
                                  (opt == `OPT_LOAD) ? `EXC_PIL : `EXC_PIS};
        else if (plv > half[3:2])
            eExcp = {valid, 9'h0, `EXC_PPI};
        else if (opt == `OPT_STORE && !half[1])
            eExcp = {valid, 9'h0, `EXC_PME};
        vaddr      = va;
        vaddrValid = valid;
        opType     = opt;
        crmd       = cr;
        dmw0       = d0;
        dmw1       = d1;
        asid       = a;
        do
        begin
            stalled = (nextRand() & 32'h3) == 32'h0;
            stall0  = stalled;
            nextCycle();
            if (!stalled)
            begin
                hValid = valid;
                hPaddr = ePaddr;
                hExcp  = eExcp;
                hMem   = eMem;
            end
            checkXlateOutputs();
        end
        while (stalled);
        stall0 = 1'b1;
    endtask

    // mode 0 direct address, 1 windows, 2 mapped
    task automatic randomXlate(input int mode);
        logic [31:0] va, r, r2, d0, d1;
        logic [8:0] cr;
        logic [1:0] opt;
        logic [`ASIDW-1:0] a;
        logic [`TLB_IDXW-1:0] k;
        r   = nextRand();
        r2  = nextRand();
        va  = nextRand();
        d0  = nextRand();
        d1  = nextRand();
        k   = r[4:0];
        a   = r[14:5];
        opt = (r[16:15] == 2'd3) ? `OPT_STORE : r[16:15];
        cr  = r2[8:0];
        if (mode == 0)
            cr[4:3] = 2'b01;
        else if (mode == 1)
        begin
            cr[4:3] = 2'b10;
            cr[1:0] = r[17] ? 2'd3 : 2'd0;
            if (r[18])
                d0[31:29] = va[31:29];
            if (r[19])
                d1[31:29] = va[31:29];
        end
        else
        begin
            cr[4:3] = 2'b10;
            d0 = '0;
            d1 = '0;
            if (r[21:20] != 2'b00)
                va[31:13] = mVppn[k];
            if (r[23:22] != 2'b00)
                a = mAsid[k];
        end
        xlateOp(va, opt, cr, d0, d1, a);
    endtask

    initial
    begin
        cycleCount = 0;
        while (cycleCount < cycleLimit)
        begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: simulation did not finish");
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        opValid    = 1'b0;
        opCode     = `OP_SRCH;
        stallW     = 1'b1;
        tlbIdxIn   = '0;
        tlbEhiIn   = '0;
        tlbElo0In  = '0;
        tlbElo1In  = '0;
        asid       = '0;
        vaddr      = '0;
        vaddrValid = 1'b0;
        opType     = `OPT_FETCH;
        stall0     = 1'b1;
        crmd       = '0;
        dmw0       = '0;
        dmw1       = '0;
        {hIdx, hEhi, hElo0, hElo1, hAsid} = '0;
        {hValid, hPaddr, hExcp, hMem} = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++)
            mE[i] = 1'b0;
        wait (rstN === 1'b1);
        nextCycle();
        checkMgmtOutputs();
        checkXlateOutputs();
        for (int i = 0; i < `TLB_ENTRIES; i++)
            writeEntry(`TLB_IDXW'(i));    // every entry gets defined fields
        for (int i = 0; i < `TLB_ENTRIES; i++)
            readEntry(`TLB_IDXW'(i));
        for (int i = `TLB_ENTRIES; i < numWrites; i++)
            writeEntry(`TLB_IDXW'(nextRand()));
        for (int i = 0; i < `TLB_ENTRIES; i++)
            readEntry(`TLB_IDXW'(i));
        for (int i = 0; i < numSearches; i++)
            searchEntry();
        if (searchHits == 0)
        begin
            failCount++;
            $display("no search was expected to hit, so hit indices went untested");
        end
        for (int i = 0; i < 100; i++)
            randomXlate(0);
        for (int i = 0; i < 100; i++)
            randomXlate(1);
        for (int i = 0; i < numXlates - 200; i++)
            randomXlate(2);
        $display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/mmuPkg.sv
verilog/tlbEntries.sv
verilog/tlbMatch.sv
verilog/tlbControl.sv
verilog/addrTranslate.sv
verilog/memMapUnit.sv
bench/mmuClock.sv
bench/mmuBench.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module mmuBench -o mmuSim
# an assertion stop exits non-zero, the log decides
./obj_dir/mmuSim > sim.log 2>&1 || true
cat sim.log
if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    exit 1
fi
